// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN        = 32;
    localparam int REG_IDX_W   = 5;
    localparam int IMEM_DEPTH  = 64;
    localparam int DMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_ADDR_W = 6;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    // r-type function codes
    localparam logic [5:0] F_ADD = 6'h20;
    localparam logic [5:0] F_SUB = 6'h22;
    localparam logic [5:0] F_AND = 6'h24;
    localparam logic [5:0] F_OR  = 6'h25;
    localparam logic [5:0] F_SLT = 6'h2a;

    localparam int ALU_OP_W = 3;
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd4;

    // operand source in execute
    localparam int FWD_W = 2;
    localparam logic [FWD_W-1:0] FWD_REG = 2'd0;
    localparam logic [FWD_W-1:0] FWD_MEM = 2'd1;
    localparam logic [FWD_W-1:0] FWD_WB  = 2'd2;

    // stores here go to the output port
    localparam logic [XLEN-1:0] OUT_ADDR = 32'h0000_0400;

    typedef union packed {
        struct packed {
            logic [5:0]           op;
            logic [REG_IDX_W-1:0] rs;
            logic [REG_IDX_W-1:0] rt;
            logic [REG_IDX_W-1:0] rd;
            logic [4:0]           shamt;
            logic [5:0]           funct;
        } r;
        struct packed {
            logic [5:0]           op;
            logic [REG_IDX_W-1:0] rs;
            logic [REG_IDX_W-1:0] rt;
            logic [15:0]          imm;
        } i;
    } instr_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module fetch_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            load_en,
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] load_addr,
    input  cpu_pkg::instr_t                 load_data,
    input  logic                            stall,
    input  logic                            branch_taken,
    input  logic [cpu_pkg::XLEN-1:0]        branch_target,
    output cpu_pkg::instr_t                 if_instr,
    output logic [cpu_pkg::XLEN-1:0]        if_pc,
    output logic                            if_valid
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc;
    instr_t          imem [IMEM_DEPTH];

    // program load only while the core is idle
    always_ff @(posedge clk) begin
        if (load_en && !run) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (!run) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (branch_taken) begin
            // wrong-path fetch becomes a bubble
            pc       <= branch_target;
            if_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + XLEN'(4);
            if_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_instr <= imem[pc[IMEM_ADDR_W+1:2]];
            if_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rs,
    input  logic [cpu_pkg::REG_IDX_W-1:0] rt,
    output logic [cpu_pkg::XLEN-1:0]      rs_data,
    output logic [cpu_pkg::XLEN-1:0]      rt_data,
    input  logic                          wb_we,
    input  logic [cpu_pkg::REG_IDX_W-1:0] wb_dest,
    input  logic [cpu_pkg::XLEN-1:0]      wb_data
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [1:2**REG_IDX_W-1];

    // r0 is hardwired, writeback bypasses the array
    function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_we && wb_dest == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < 2**REG_IDX_W; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_we && wb_dest != '0) begin
            regs[wb_dest] <= wb_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs);
        rt_data = read_port(rt);
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  cpu_pkg::instr_t               if_instr,
    input  logic [cpu_pkg::XLEN-1:0]      if_pc,
    input  logic                          if_valid,
    input  logic                          stall,
    input  logic                          wb_we,
    input  logic [cpu_pkg::REG_IDX_W-1:0] wb_dest,
    input  logic [cpu_pkg::XLEN-1:0]      wb_data,
    output logic [cpu_pkg::REG_IDX_W-1:0] id_rs,
    output logic [cpu_pkg::REG_IDX_W-1:0] id_rt,
    output logic                          id_uses_rs,
    output logic                          id_uses_rt,
    output logic                          id_branch,
    output logic                          branch_taken,
    output logic [cpu_pkg::XLEN-1:0]      branch_target,
    output logic                          ex_valid,
    output logic [cpu_pkg::ALU_OP_W-1:0]  ex_alu_op,
    output logic [cpu_pkg::XLEN-1:0]      ex_a,
    output logic [cpu_pkg::XLEN-1:0]      ex_b,
    output logic [cpu_pkg::XLEN-1:0]      ex_imm,
    output logic                          ex_use_imm,
    output logic [cpu_pkg::REG_IDX_W-1:0] ex_rs,
    output logic [cpu_pkg::REG_IDX_W-1:0] ex_rt,
    output logic [cpu_pkg::REG_IDX_W-1:0] ex_dest,
    output logic                          ex_we,
    output logic                          ex_mem_read,
    output logic                          ex_mem_write
);
    import cpu_pkg::*;

    logic [XLEN-1:0]      rs_data;
    logic [XLEN-1:0]      rt_data;
    logic [XLEN-1:0]      imm;
    logic [ALU_OP_W-1:0]  alu_op;
    logic [REG_IDX_W-1:0] dest;
    logic                 known;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 use_imm;
    logic                 we;
    logic                 mem_read;
    logic                 mem_write;
    logic                 is_branch;
    logic                 bubble;

    assign id_rs = if_instr.r.rs;
    assign id_rt = if_instr.r.rt;

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs      (id_rs),
        .rt      (id_rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_dest (wb_dest),
        .wb_data (wb_data)
    );

    always_comb begin
        known     = 1'b1;
        alu_op    = ALU_ADD;
        dest      = if_instr.i.rt;
        uses_rs   = 1'b1;
        uses_rt   = 1'b0;
        use_imm   = 1'b0;
        we        = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        case (if_instr.r.op)
            OP_RTYPE: begin
                dest    = if_instr.r.rd;
                uses_rt = 1'b1;
                we      = 1'b1;
                case (if_instr.r.funct)
                    F_ADD:   alu_op = ALU_ADD;
                    F_SUB:   alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_SLT:   alu_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: begin
                use_imm = 1'b1;
                we      = 1'b1;
            end
            OP_LW: begin
                use_imm  = 1'b1;
                we       = 1'b1;
                mem_read = 1'b1;
            end
            OP_SW: begin
                use_imm   = 1'b1;
                uses_rt   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                uses_rt   = 1'b1;
                is_branch = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    assign imm = {{(XLEN-16){if_instr.i.imm[15]}}, if_instr.i.imm};

    assign id_uses_rs = if_valid && known && uses_rs;
    assign id_uses_rt = if_valid && known && uses_rt;
    assign id_branch  = if_valid && is_branch;

    // resolved here so only one fetched slot is lost
    assign branch_target = if_pc + XLEN'(4) + (imm << 2);
    assign branch_taken  = run && id_branch && !stall
                           && ((rs_data == rt_data) != (if_instr.r.op == OP_BNE));

    assign bubble = !run || stall || !if_valid || !known;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_we        <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else begin
            ex_valid     <= !bubble;
            ex_we        <= !bubble && we;
            ex_mem_read  <= !bubble && mem_read;
            ex_mem_write <= !bubble && mem_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_alu_op  <= alu_op;
        ex_a       <= rs_data;
        ex_b       <= rt_data;
        ex_imm     <= imm;
        ex_use_imm <= use_imm;
        ex_rs      <= id_rs;
        ex_rt      <= id_rt;
        ex_dest    <= dest;
    end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module hazard_unit (
    input  logic [cpu_pkg::REG_IDX_W-1:0] id_rs,
    input  logic [cpu_pkg::REG_IDX_W-1:0] id_rt,
    input  logic                          id_uses_rs,
    input  logic                          id_uses_rt,
    input  logic                          id_branch,
    input  logic                          ex_valid,
    input  logic [cpu_pkg::REG_IDX_W-1:0] ex_rs,
    input  logic [cpu_pkg::REG_IDX_W-1:0] ex_rt,
    input  logic [cpu_pkg::REG_IDX_W-1:0] ex_dest,
    input  logic                          ex_we,
    input  logic                          ex_mem_read,
    input  logic [cpu_pkg::REG_IDX_W-1:0] mem_dest,
    input  logic                          mem_we,
    input  logic [cpu_pkg::REG_IDX_W-1:0] wb_dest,
    input  logic                          wb_we,
    output logic                          stall,
    output logic [cpu_pkg::FWD_W-1:0]     fwd_a,
    output logic [cpu_pkg::FWD_W-1:0]     fwd_b
);
    import cpu_pkg::*;

    logic load_use;
    logic branch_dep;

    // does a pending write hit a source that decode actually reads
    function automatic logic id_hit(input logic [REG_IDX_W-1:0] dest, input logic wr);
        return wr && dest != '0
               && ((id_uses_rs && id_rs == dest) || (id_uses_rt && id_rt == dest));
    endfunction

    // youngest producer wins
    function automatic logic [FWD_W-1:0] pick(input logic [REG_IDX_W-1:0] src,
                                              input logic [REG_IDX_W-1:0] m_dest,
                                              input logic                 m_we,
                                              input logic [REG_IDX_W-1:0] w_dest,
                                              input logic                 w_we);
        if (src == '0) begin
            return FWD_REG;
        end
        if (m_we && m_dest == src) begin
            return FWD_MEM;
        end
        if (w_we && w_dest == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        load_use   = id_hit(ex_dest, ex_valid && ex_mem_read);
        branch_dep = id_branch && (id_hit(ex_dest, ex_valid && ex_we) || id_hit(mem_dest, mem_we));
        stall      = load_use || branch_dep;
        fwd_a      = pick(ex_rs, mem_dest, mem_we, wb_dest, wb_we);
        fwd_b      = pick(ex_rt, mem_dest, mem_we, wb_dest, wb_we);
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          ex_valid,
    input  logic [cpu_pkg::ALU_OP_W-1:0]  ex_alu_op,
    input  logic [cpu_pkg::XLEN-1:0]      ex_a,
    input  logic [cpu_pkg::XLEN-1:0]      ex_b,
    input  logic [cpu_pkg::XLEN-1:0]      ex_imm,
    input  logic                          ex_use_imm,
    input  logic [cpu_pkg::REG_IDX_W-1:0] ex_dest,
    input  logic                          ex_we,
    input  logic                          ex_mem_read,
    input  logic                          ex_mem_write,
    input  logic [cpu_pkg::FWD_W-1:0]     fwd_a,
    input  logic [cpu_pkg::FWD_W-1:0]     fwd_b,
    input  logic [cpu_pkg::XLEN-1:0]      wb_data,
    output logic                          mem_valid,
    output logic [cpu_pkg::XLEN-1:0]      mem_result,
    output logic [cpu_pkg::XLEN-1:0]      mem_store_data,
    output logic [cpu_pkg::REG_IDX_W-1:0] mem_dest,
    output logic                          mem_we,
    output logic                          mem_mem_read,
    output logic                          mem_mem_write
);
    import cpu_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_y;

    function automatic logic [XLEN-1:0] fwd_mux(input logic [FWD_W-1:0] sel,
                                                 input logic [XLEN-1:0]  reg_val,
                                                 input logic [XLEN-1:0]  mem_val,
                                                 input logic [XLEN-1:0]  wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a   = fwd_mux(fwd_a, ex_a, mem_result, wb_data);
    // forwarded rt doubles as store data
    assign rt_val = fwd_mux(fwd_b, ex_b, mem_result, wb_data);
    assign op_b   = ex_use_imm ? ex_imm : rt_val;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_y = op_a + op_b;
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_y = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid     <= 1'b0;
            mem_we        <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else begin
            mem_valid     <= run && ex_valid;
            mem_we        <= run && ex_we;
            mem_mem_read  <= run && ex_mem_read;
            mem_mem_write <= run && ex_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        mem_result     <= alu_y;
        mem_store_data <= rt_val;
        mem_dest       <= ex_dest;
    end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module memory_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic                          mem_valid,
    input  logic [cpu_pkg::XLEN-1:0]      mem_result,
    input  logic [cpu_pkg::XLEN-1:0]      mem_store_data,
    input  logic [cpu_pkg::REG_IDX_W-1:0] mem_dest,
    input  logic                          mem_we,
    input  logic                          mem_mem_read,
    input  logic                          mem_mem_write,
    output logic                          out_valid,
    output logic [cpu_pkg::XLEN-1:0]      out_data,
    output logic                          wb_we,
    output logic [cpu_pkg::REG_IDX_W-1:0] wb_dest,
    output logic [cpu_pkg::XLEN-1:0]      wb_data
);
    import cpu_pkg::*;

    logic [XLEN-1:0]        dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] word;
    logic                   port_store;
    logic                   wb_mem_read;
    logic [XLEN-1:0]        wb_alu;
    logic [XLEN-1:0]        wb_load;

    assign word       = mem_result[DMEM_ADDR_W+1:2];
    assign port_store = mem_valid && mem_mem_write && mem_result == OUT_ADDR;

    // port stores never reach memory
    always_ff @(posedge clk) begin
        if (mem_valid && mem_mem_write && !port_store) begin
            dmem[word] <= mem_store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wb_we     <= 1'b0;
        end else begin
            out_valid <= run && port_store;
            wb_we     <= run && mem_valid && mem_we;
        end
    end

    always_ff @(posedge clk) begin
        if (port_store) begin
            out_data <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest     <= mem_dest;
        wb_mem_read <= mem_mem_read;
        wb_alu      <= mem_result;
        wb_load     <= dmem[word];
    end

    assign wb_data = wb_mem_read ? wb_load : wb_alu;

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            load_en,
    input  logic [cpu_pkg::IMEM_ADDR_W-1:0] load_addr,
    input  cpu_pkg::instr_t                 load_data,
    output logic                            out_valid,
    output logic [cpu_pkg::XLEN-1:0]        out_data
);
    import cpu_pkg::*;

    // fetch and branch
    instr_t          if_instr;
    logic [XLEN-1:0] if_pc;
    logic            if_valid;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;

    // decode toward hazard detection
    logic [REG_IDX_W-1:0] id_rs;
    logic [REG_IDX_W-1:0] id_rt;
    logic                 id_uses_rs;
    logic                 id_uses_rt;
    logic                 id_branch;
    logic                 stall;
    logic [FWD_W-1:0]     fwd_a;
    logic [FWD_W-1:0]     fwd_b;

    // decode to execute
    logic                 ex_valid;
    logic [ALU_OP_W-1:0]  ex_alu_op;
    logic [XLEN-1:0]      ex_a;
    logic [XLEN-1:0]      ex_b;
    logic [XLEN-1:0]      ex_imm;
    logic                 ex_use_imm;
    logic [REG_IDX_W-1:0] ex_rs;
    logic [REG_IDX_W-1:0] ex_rt;
    logic [REG_IDX_W-1:0] ex_dest;
    logic                 ex_we;
    logic                 ex_mem_read;
    logic                 ex_mem_write;

    // execute to memory
    logic                 mem_valid;
    logic [XLEN-1:0]      mem_result;
    logic [XLEN-1:0]      mem_store_data;
    logic [REG_IDX_W-1:0] mem_dest;
    logic                 mem_we;
    logic                 mem_mem_read;
    logic                 mem_mem_write;

    // writeback, also the forwarding source
    logic                 wb_we;
    logic [REG_IDX_W-1:0] wb_dest;
    logic [XLEN-1:0]      wb_data;

    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    hazard_unit   u_hazard  (.*);
    execute_stage u_execute (.*);
    memory_stage  u_memory  (.*);

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int IDLE_END  = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   run;
    logic                   load_en;
    logic [IMEM_ADDR_W-1:0] load_addr;
    instr_t                 load_data;
    logic                   out_valid;
    logic [XLEN-1:0]        out_data;

    instr_t          prog [$];
    logic [XLEN-1:0] exp_q [$];
    logic [XLEN-1:0] exp_head;
    logic            exp_empty;
    logic [XLEN-1:0] ref_regs [32];
    logic [XLEN-1:0] ref_mem [DMEM_DEPTH];
    string           test_name;
    int              n_expected;
    int              pulses;
    int              idle_cycles;
    int              errors;
    int              checks;
    int              tests_run;
    int              cycles;
    int              cycle_limit;

    cpu_top dut (.*);

    always #5 clk = ~clk;

    // value check on every output pulse
    assert property (@(posedge clk) out_valid && !exp_empty |-> out_data == exp_head)
        else begin
            $display("MISMATCH %s expected %08h actual %08h",
                     test_name, $sampled(exp_head), $sampled(out_data));
            errors++;
        end

    assert property (@(posedge clk) out_valid |-> !exp_empty)
        else begin
            $display("%s: output pulse with no value left to expect", test_name);
            errors++;
        end

    assert property (@(posedge clk) (!rst_n || !run) |-> !out_valid)
        else begin
            $display("%s: output pulse while in reset or not running", test_name);
            errors++;
        end

    // pop the expected head after each pulse
    always @(posedge clk) begin
        if (!run) begin
            pulses      <= 0;
            idle_cycles <= 0;
        end else if (out_valid) begin
            pulses      <= pulses + 1;
            checks++;
            idle_cycles <= 0;
            if (exp_q.size() > 0) begin
                exp_q.delete(0);
            end
        end else if (exp_q.size() == 0) begin
            idle_cycles <= idle_cycles + 1;
        end
        exp_empty = (exp_q.size() == 0);
        exp_head  = exp_empty ? '0 : exp_q[0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run timed out after %0d cycles in %s", cycles, test_name);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic instr_t make_r(input logic [5:0] funct, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt);
        instr_t w;
        w         = '0;
        w.r.op    = OP_RTYPE;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.rd    = rd;
        w.r.funct = funct;
        return w;
    endfunction

    function automatic instr_t make_i(input logic [5:0] op, input logic [4:0] rt,
                                      input logic [4:0] rs, input logic [15:0] imm);
        instr_t w;
        w.i.op  = op;
        w.i.rs  = rs;
        w.i.rt  = rt;
        w.i.imm = imm;
        return w;
    endfunction

    task automatic put_r(input logic [5:0] funct, input int rd, input int rs, input int rt);
        prog.push_back(make_r(funct, 5'(rd), 5'(rs), 5'(rt)));
    endtask

    task automatic put_i(input logic [5:0] op, input int rt, input int rs, input int imm);
        prog.push_back(make_i(op, 5'(rt), 5'(rs), 16'(imm)));
    endtask

    task automatic put_out(input int rt);
        put_i(OP_SW, rt, 0, 32'h400);
    endtask

    task automatic set_reg(input logic [4:0] idx, input logic [XLEN-1:0] val);
        if (idx != 0) begin
            ref_regs[idx] = val;
        end
    endtask

    // instruction-level model that stops at the branch to itself
    task automatic interpret(output int steps);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] addr;
        instr_t          w;
        logic            taken;
        logic            done;
        steps = 0;
        pc    = 0;
        done  = 0;
        while (!done) begin
            if (pc[31:2] >= prog.size() || steps > 2000) begin
                $display("%s: reference model left the program at pc %08h", test_name, pc);
                errors++;
                break;
            end
            w     = prog[pc[31:2]];
            a     = ref_regs[w.r.rs];
            b     = ref_regs[w.r.rt];
            imm   = {{16{w.i.imm[15]}}, w.i.imm};
            addr  = a + imm;
            next  = pc + 4;
            steps++;
            case (w.r.op)
                OP_RTYPE: begin
                    case (w.r.funct)
                        F_ADD: set_reg(w.r.rd, a + b);
                        F_SUB: set_reg(w.r.rd, a - b);
                        F_AND: set_reg(w.r.rd, a & b);
                        F_OR:  set_reg(w.r.rd, a | b);
                        F_SLT: set_reg(w.r.rd, {31'b0, $signed(a) < $signed(b)});
                        default: ;
                    endcase
                end
                OP_ADDI: set_reg(w.i.rt, a + imm);
                OP_LW:   set_reg(w.i.rt, ref_mem[addr[DMEM_ADDR_W+1:2]]);
                OP_SW: begin
                    if (addr == OUT_ADDR) begin
                        exp_q.push_back(b);
                    end else begin
                        ref_mem[addr[DMEM_ADDR_W+1:2]] = b;
                    end
                end
                OP_BEQ, OP_BNE: begin
                    taken = (a == b) ^ (w.r.op == OP_BNE);
                    if (taken) begin
                        next = pc + 4 + (imm << 2);
                        done = (next == pc);
                    end
                end
                default: ;
            endcase
            pc = next;
        end
    endtask

    task automatic run_test(input string name, input int hold);
        int steps;
        int k;
        int err_before;
        test_name  = name;
        err_before = errors;
        interpret(steps);
        n_expected  = exp_q.size();
        cycle_limit += 8 * steps;
        @(posedge clk);
        run <= 1'b0;
        for (k = 0; k < prog.size(); k++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= IMEM_ADDR_W'(k);
            load_data <= prog[k];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (hold) @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        while (idle_cycles < IDLE_END) begin
            @(posedge clk);
        end
        checks++;
        assert (pulses == n_expected)
            else begin
                $display("MISMATCH %s pulse count expected %0d actual %0d",
                         name, n_expected, pulses);
                errors++;
            end
        tests_run++;
        $display("test %-10s %0d pulses, %0d instructions, %s", name, pulses, steps,
                 (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic build_random(input int n);
        int k;
        int rd;
        logic [5:0] funct;
        for (k = 0; k < n; k++) begin
            rd = $urandom_range(1, 15);
            case ($urandom_range(0, 5))
                0: funct = F_ADD;
                1: funct = F_SUB;
                2: funct = F_AND;
                3: funct = F_OR;
                4: funct = F_SLT;
                default: funct = '0;
            endcase
            if (funct == '0) begin
                put_i(OP_ADDI, rd, $urandom_range(0, 15), $urandom);
            end else begin
                put_r(funct, rd, $urandom_range(0, 15), $urandom_range(0, 15));
            end
            put_out(rd);
        end
    endtask

    initial begin
        int loop_top;
        void'($urandom(32'hf084_dd7b));
        clk         = 1'b0;
        rst_n       = 1'b0;
        run         = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        exp_empty   = 1'b1;
        exp_head    = '0;
        test_name   = "reset";
        cycle_limit = 100 * NUM_TESTS;
        foreach (ref_regs[k]) ref_regs[k] = '0;
        foreach (ref_mem[k]) ref_mem[k] = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // program sits loaded while run stays low
        prog.delete();
        put_i(OP_ADDI, 1, 0, 32'h5a);
        put_out(1);
        put_i(OP_BEQ, 0, 0, -1);
        run_test("idle_hold", 30);

        prog.delete();
        put_i(OP_ADDI, 1, 0, 5);
        put_i(OP_ADDI, 2, 1, 3);
        put_r(F_ADD, 3, 1, 2);
        put_r(F_SUB, 4, 3, 1);
        put_r(F_AND, 5, 4, 3);
        put_r(F_OR, 6, 5, 1);
        put_r(F_SLT, 7, 4, 3);
        put_i(OP_ADDI, 8, 0, -3);
        put_r(F_SLT, 9, 8, 1);
        for (int r = 2; r <= 9; r++) put_out(r);
        put_r(F_SUB, 10, 8, 6);
        put_out(10);
        put_i(OP_BEQ, 0, 0, -1);
        run_test("alu_chain", 2);

        prog.delete();
        put_i(OP_ADDI, 10, 0, 100);
        put_i(OP_ADDI, 11, 0, 32'h40);
        put_i(OP_SW, 10, 11, 0);
        put_i(OP_LW, 12, 11, 0);
        put_r(F_ADD, 13, 12, 10);
        put_out(13);
        put_i(OP_LW, 14, 11, 0);
        put_out(14);
        put_i(OP_ADDI, 15, 14, 1);
        put_i(OP_SW, 15, 11, 4);
        put_i(OP_LW, 16, 11, 4);
        put_out(16);
        put_i(OP_BEQ, 0, 0, -1);
        run_test("load_use", 2);

        prog.delete();
        put_i(OP_ADDI, 1, 0, 3);
        loop_top = prog.size();
        put_out(1);
        put_i(OP_ADDI, 1, 1, -1);
        put_i(OP_BNE, 0, 1, loop_top - prog.size() - 1);
        put_i(OP_ADDI, 2, 0, 9);
        put_i(OP_BEQ, 0, 2, 1);
        put_out(2);
        put_i(OP_ADDI, 3, 0, 9);
        put_i(OP_BEQ, 2, 3, 1);
        put_out(0);
        put_out(3);
        put_i(OP_BEQ, 0, 0, -1);
        run_test("branches", 2);

        // 40 random instructions split in two halves to fit the 64-word imem
        prog.delete();
        build_random(20);
        put_i(OP_BEQ, 0, 0, -1);
        run_test("random_a", 2);

        prog.delete();
        build_random(20);
        put_i(OP_BEQ, 0, 0, -1);
        run_test("random_b", 2);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
cpu_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: cpu_pipeline

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - register_file.sv
  - decode_stage.sv
  - hazard_unit.sv
  - execute_stage.sv
  - memory_stage.sv
  - cpu_top.sv
  - target: simulation
    files:
      - tb_cpu.sv
